// File: Makefile
# Verilator build and run of the column PE testbench

VERILATOR ?= verilator
TOP       ?= tb_align_column_pe
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
source/align_pkg.sv
source/column_fsm.sv
source/column_counter.sv
source/gap_open_stage.sv
source/cell_resolve_stage.sv
source/column_max_tracker.sv
source/align_column_pe.sv
test/column_checker.sv
test/tb_align_column_pe.sv

// File: source/align_column_pe.sv
`timescale 1ns/1ps

module align_column_pe import align_pkg::*; #(
	parameter int ROW_WIDTH = 8,
	parameter int GAP_OPEN1 = 14,
	parameter int GAP_EXT1  = 2,
	parameter int GAP_OPEN2 = 25,
	parameter int GAP_EXT2  = 1
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        col_start_valid,
	input  col_start_t  col_start,
	input  logic        cell_valid,
	input  cell_in_t    cell_in,
	output logic        cell_out_valid,
	output cell_out_t   cell_out,
	output logic        col_done,
	output col_result_t col_result
);

	logic                 col_load;
	logic                 cell_accept;
	logic                 last_cell;
	logic [ROW_WIDTH-1:0] row;
	logic                 stage_valid;
	stage_t               stage_data;
	logic [ROW_WIDTH-1:0] out_row;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	column_fsm u_fsm (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.col_start_valid (col_start_valid),
		.cell_valid      (cell_valid),
		.last_cell       (last_cell),
		.col_load        (col_load),
		.cell_accept     (cell_accept),
		.col_done        (col_done)
	);

	column_counter #(.ROW_WIDTH(ROW_WIDTH)) u_counter (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.col_load    (col_load),
		.length      (col_start.length),
		.cell_accept (cell_accept),
		.row         (row),
		.last_cell   (last_cell)
	);

	////////////////////////////////////////////////////////////
	// Datapath, two stages then the column maximum
	////////////////////////////////////////////////////////////

	gap_open_stage #(
		.ROW_WIDTH (ROW_WIDTH),
		.GAP_OPEN1 (GAP_OPEN1),
		.GAP_EXT1  (GAP_EXT1),
		.GAP_OPEN2 (GAP_OPEN2),
		.GAP_EXT2  (GAP_EXT2)
	) u_stage1 (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.col_load    (col_load),
		.col_start   (col_start),
		.cell_accept (cell_accept),
		.cell_in     (cell_in),
		.row         (row),
		.stage_valid (stage_valid),
		.stage_data  (stage_data)
	);

	cell_resolve_stage #(
		.ROW_WIDTH (ROW_WIDTH),
		.GAP_OPEN1 (GAP_OPEN1),
		.GAP_EXT1  (GAP_EXT1),
		.GAP_OPEN2 (GAP_OPEN2),
		.GAP_EXT2  (GAP_EXT2)
	) u_stage2 (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.col_load       (col_load),
		.h_top          (col_start.h_top),
		.stage_valid    (stage_valid),
		.stage_data     (stage_data),
		.cell_out_valid (cell_out_valid),
		.cell_out       (cell_out),
		.out_row        (out_row)
	);

	column_max_tracker #(.ROW_WIDTH(ROW_WIDTH)) u_max (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.col_load       (col_load),
		.cell_out_valid (cell_out_valid),
		.h              (cell_out.h),
		.out_row        (out_row),
		.col_result     (col_result)
	);

endmodule

// File: source/align_pkg.sv
package align_pkg;

	localparam int SCORE_WIDTH = 16;
	localparam int BASE_WIDTH  = 4;
	// Same value as ROW_WIDTH at the top level
	localparam int ROW_BITS    = 8;

	typedef logic signed [SCORE_WIDTH-1:0] score_t;
	typedef logic [BASE_WIDTH-1:0] base_t;
	typedef logic [ROW_BITS-1:0] row_t;

	localparam score_t MATCH_SCORE    = 16'sd2;
	localparam score_t MISMATCH_SCORE = -16'sd4;
	// Empty gap state, leaves headroom below it for penalty subtraction
	localparam score_t MINUS_INF      = -16'sd28672;

	typedef enum logic [1:0] {
		H_SRC_DIAG,
		H_SRC_VGAP,
		H_SRC_HGAP
	} h_src_t;

	// Traceback code, 7 bits
	typedef struct packed {
		h_src_t h_src;
		logic   gap_model2;
		logic   e1_ext;
		logic   e2_ext;
		logic   f1_ext;
		logic   f2_ext;
	} bt_t;

	typedef struct packed {
		base_t  read_base;
		score_t h_top;
		score_t h_diag_top;
		row_t   length;
	} col_start_t;

	typedef struct packed {
		base_t  ref_base;
		score_t h_left;
		score_t f1_left;
		score_t f2_left;
	} cell_in_t;

	// Between the two pipeline stages
	typedef struct packed {
		score_t m;
		score_t f1;
		score_t f2;
		logic   f1_ext;
		logic   f2_ext;
		row_t   row;
	} stage_t;

	typedef struct packed {
		score_t h;
		score_t e1;
		score_t e2;
		score_t f1;
		score_t f2;
		bt_t    bt;
	} cell_out_t;

	typedef struct packed {
		score_t max_h;
		row_t   max_row;
	} col_result_t;

endpackage

// File: source/cell_resolve_stage.sv
`timescale 1ns/1ps

module cell_resolve_stage import align_pkg::*; #(
	parameter int ROW_WIDTH = 8,
	parameter int GAP_OPEN1 = 14,
	parameter int GAP_EXT1  = 2,
	parameter int GAP_OPEN2 = 25,
	parameter int GAP_EXT2  = 1
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 col_load,
	input  score_t               h_top,
	input  logic                 stage_valid,
	input  stage_t               stage_data,
	output logic                 cell_out_valid,
	output cell_out_t            cell_out,
	output logic [ROW_WIDTH-1:0] out_row
);

	localparam score_t OPEN1 = score_t'(GAP_OPEN1);
	localparam score_t EXT1  = score_t'(GAP_EXT1);
	localparam score_t OPEN2 = score_t'(GAP_OPEN2);
	localparam score_t EXT2  = score_t'(GAP_EXT2);

	// Values of the row above
	score_t h_prev;
	score_t e1_prev;
	score_t e2_prev;

	score_t e1_ext_c;
	score_t e1_open_c;
	score_t e2_ext_c;
	score_t e2_open_c;
	score_t e1_new;
	score_t e2_new;
	score_t best_e;
	score_t best_f;
	logic   e_is2;
	logic   f_is2;
	score_t h_new;
	bt_t    bt_new;

	assign e1_ext_c  = e1_prev - EXT1;
	assign e1_open_c = h_prev - OPEN1;
	assign e2_ext_c  = e2_prev - EXT2;
	assign e2_open_c = h_prev - OPEN2;

	assign e1_new = (e1_ext_c > e1_open_c) ? e1_ext_c : e1_open_c;
	assign e2_new = (e2_ext_c > e2_open_c) ? e2_ext_c : e2_open_c;

	// Model 1 keeps ties
	assign e_is2  = (e2_new > e1_new);
	assign f_is2  = (stage_data.f2 > stage_data.f1);
	assign best_e = e_is2 ? e2_new : e1_new;
	assign best_f = f_is2 ? stage_data.f2 : stage_data.f1;

	////////////////////////////////////////////////////////////
	// H selection, ties to M then E then F
	////////////////////////////////////////////////////////////

	always_comb begin
		bt_new.e1_ext = (e1_ext_c > e1_open_c);
		bt_new.e2_ext = (e2_ext_c > e2_open_c);
		bt_new.f1_ext = stage_data.f1_ext;
		bt_new.f2_ext = stage_data.f2_ext;
		if (stage_data.m >= best_e && stage_data.m >= best_f) begin
			h_new             = stage_data.m;
			bt_new.h_src      = H_SRC_DIAG;
			bt_new.gap_model2 = 1'b0;
		end else if (best_e >= best_f) begin
			h_new             = best_e;
			bt_new.h_src      = H_SRC_VGAP;
			bt_new.gap_model2 = e_is2;
		end else begin
			h_new             = best_f;
			bt_new.h_src      = H_SRC_HGAP;
			bt_new.gap_model2 = f_is2;
		end
	end

	// Vertical feedback, seeded by the boundary above row 0
	always_ff @(posedge sys_clk) begin
		if (col_load) begin
			h_prev  <= h_top;
			e1_prev <= MINUS_INF;
			e2_prev <= MINUS_INF;
		end else if (stage_valid) begin
			h_prev  <= h_new;
			e1_prev <= e1_new;
			e2_prev <= e2_new;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cell_out_valid <= 1'b0;
		end else begin
			cell_out_valid <= stage_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (stage_valid) begin
			cell_out.h  <= h_new;
			cell_out.e1 <= e1_new;
			cell_out.e2 <= e2_new;
			cell_out.f1 <= stage_data.f1;
			cell_out.f2 <= stage_data.f2;
			cell_out.bt <= bt_new;
			out_row     <= stage_data.row;
		end
	end

endmodule

// File: source/column_counter.sv
`timescale 1ns/1ps

module column_counter #(
	parameter int ROW_WIDTH = 8
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 col_load,
	input  logic [ROW_WIDTH-1:0] length,
	input  logic                 cell_accept,
	output logic [ROW_WIDTH-1:0] row,
	output logic                 last_cell
);

	logic [ROW_WIDTH-1:0] col_len;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			row     <= '0;
			col_len <= '0;
		end else if (col_load) begin
			row     <= '0;
			col_len <= length;
		end else if (cell_accept) begin
			row <= row + 1'b1;
		end
	end

	// Current row is the final one of the column
	assign last_cell = (row == col_len - 1'b1);

endmodule

// File: source/column_fsm.sv
`timescale 1ns/1ps

module column_fsm (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic col_start_valid,
	input  logic cell_valid,
	input  logic last_cell,
	output logic col_load,
	output logic cell_accept,
	output logic col_done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RUN,
		ST_FLUSH,
		ST_SETTLE,
		ST_DONE
	} state_t;

	state_t state;
	state_t state_nxt;

	// Starts only count when idle, cells only while running
	assign col_load    = col_start_valid && (state == ST_IDLE);
	assign cell_accept = cell_valid && (state == ST_RUN);
	assign col_done    = (state == ST_DONE);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (col_load) begin
					state_nxt = ST_RUN;
				end
			end
			ST_RUN: begin
				if (cell_accept && last_cell) begin
					state_nxt = ST_FLUSH;
				end
			end
			// Two cycles for the last cell to leave both stages
			ST_FLUSH:  state_nxt = ST_SETTLE;
			ST_SETTLE: state_nxt = ST_DONE;
			ST_DONE:   state_nxt = ST_IDLE;
			default:   state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// File: source/column_max_tracker.sv
`timescale 1ns/1ps

module column_max_tracker import align_pkg::*; #(
	parameter int ROW_WIDTH = 8
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 col_load,
	input  logic                 cell_out_valid,
	input  score_t               h,
	input  logic [ROW_WIDTH-1:0] out_row,
	output col_result_t          col_result
);

	logic take_new;

	// Strictly greater, so the earliest row keeps a tie
	assign take_new = cell_out_valid && (h > col_result.max_h);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			col_result.max_h   <= MINUS_INF;
			col_result.max_row <= '0;
		end else if (col_load) begin
			col_result.max_h   <= MINUS_INF;
			col_result.max_row <= '0;
		end else if (take_new) begin
			col_result.max_h   <= h;
			col_result.max_row <= out_row;
		end
	end

endmodule

// File: source/gap_open_stage.sv
`timescale 1ns/1ps

module gap_open_stage import align_pkg::*; #(
	parameter int ROW_WIDTH = 8,
	parameter int GAP_OPEN1 = 14,
	parameter int GAP_EXT1  = 2,
	parameter int GAP_OPEN2 = 25,
	parameter int GAP_EXT2  = 1
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 col_load,
	input  col_start_t           col_start,
	input  logic                 cell_accept,
	input  cell_in_t             cell_in,
	input  logic [ROW_WIDTH-1:0] row,
	output logic                 stage_valid,
	output stage_t               stage_data
);

	localparam score_t OPEN1 = score_t'(GAP_OPEN1);
	localparam score_t EXT1  = score_t'(GAP_EXT1);
	localparam score_t OPEN2 = score_t'(GAP_OPEN2);
	localparam score_t EXT2  = score_t'(GAP_EXT2);

	base_t  read_base;
	score_t diag_h;

	score_t sub_score;
	score_t f1_ext_c;
	score_t f1_open_c;
	score_t f2_ext_c;
	score_t f2_open_c;

	////////////////////////////////////////////////////////////
	// Column state: read base and diagonal H
	////////////////////////////////////////////////////////////

	// h_left of this row is the diagonal of the next one
	always_ff @(posedge sys_clk) begin
		if (col_load) begin
			read_base <= col_start.read_base;
			diag_h    <= col_start.h_diag_top;
		end else if (cell_accept) begin
			diag_h <= cell_in.h_left;
		end
	end

	assign sub_score = (cell_in.ref_base == read_base) ? MATCH_SCORE : MISMATCH_SCORE;

	// Horizontal gaps, both models
	assign f1_ext_c  = cell_in.f1_left - EXT1;
	assign f1_open_c = cell_in.h_left - OPEN1;
	assign f2_ext_c  = cell_in.f2_left - EXT2;
	assign f2_open_c = cell_in.h_left - OPEN2;

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= cell_accept;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cell_accept) begin
			stage_data.m      <= diag_h + sub_score;
			stage_data.f1     <= (f1_ext_c > f1_open_c) ? f1_ext_c : f1_open_c;
			stage_data.f2     <= (f2_ext_c > f2_open_c) ? f2_ext_c : f2_open_c;
			stage_data.f1_ext <= (f1_ext_c > f1_open_c);
			stage_data.f2_ext <= (f2_ext_c > f2_open_c);
			stage_data.row    <= row;
		end
	end

endmodule

// File: test/column_checker.sv
`timescale 1ns/1ps

module column_checker import align_pkg::*; #(
	parameter int GAP_OPEN1 = 14,
	parameter int GAP_EXT1  = 2,
	parameter int GAP_OPEN2 = 25,
	parameter int GAP_EXT2  = 1
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        col_start_valid,
	input  col_start_t  col_start,
	input  logic        cell_valid,
	input  cell_in_t    cell_in,
	input  logic        cell_out_valid,
	input  cell_out_t   cell_out,
	input  logic        col_done,
	input  col_result_t col_result,
	input  logic        test_end,
	input  int          test_num,
	input  logic        run_end,
	output int          error_count
);

	localparam int MATCH        = 2;
	localparam int MISMATCH     = -4;
	localparam int NEG_INF      = -28672;
	localparam int CELL_LATENCY = 2;
	localparam int DONE_LATENCY = 3;

	// Expected cells and the cycle each one is due
	cell_out_t exp_q[$];
	int        due_q[$];
	cell_out_t exp_cell;
	int        exp_due;

	int    cyc;
	int    done_due;
	bit    busy;
	bit    running;
	bit    take_cell;
	base_t read_base;
	int    col_len;
	int    row;
	int    diag;
	int    prev_h;
	int    prev_e1;
	int    prev_e2;
	int    max_h;
	int    max_row;
	int    test_cells;
	int    test_errors;
	int    total_cells;
	int    columns;

	task automatic flag(input string msg);
		$display("%s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			flag($sformatf("FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model of one cell
	////////////////////////////////////////////////////////////

	task automatic model_cell(input cell_in_t c);
		int        m;
		int        f1_e, f1_o, f2_e, f2_o;
		int        e1_e, e1_o, e2_e, e2_o;
		int        f1, f2, e1, e2;
		int        best_e, best_f, h;
		cell_out_t x;
		m    = diag + ((c.ref_base == read_base) ? MATCH : MISMATCH);
		f1_e = int'(c.f1_left) - GAP_EXT1;
		f1_o = int'(c.h_left) - GAP_OPEN1;
		f2_e = int'(c.f2_left) - GAP_EXT2;
		f2_o = int'(c.h_left) - GAP_OPEN2;
		e1_e = prev_e1 - GAP_EXT1;
		e1_o = prev_h - GAP_OPEN1;
		e2_e = prev_e2 - GAP_EXT2;
		e2_o = prev_h - GAP_OPEN2;
		f1   = (f1_e > f1_o) ? f1_e : f1_o;
		f2   = (f2_e > f2_o) ? f2_e : f2_o;
		e1   = (e1_e > e1_o) ? e1_e : e1_o;
		e2   = (e2_e > e2_o) ? e2_e : e2_o;
		x.bt.f1_ext = (f1_e > f1_o);
		x.bt.f2_ext = (f2_e > f2_o);
		x.bt.e1_ext = (e1_e > e1_o);
		x.bt.e2_ext = (e2_e > e2_o);
		// Model 1 wins a tie between the two gap models
		best_e = (e2 > e1) ? e2 : e1;
		best_f = (f2 > f1) ? f2 : f1;
		if (m >= best_e && m >= best_f) begin
			h               = m;
			x.bt.h_src      = H_SRC_DIAG;
			x.bt.gap_model2 = 1'b0;
		end else if (best_e >= best_f) begin
			h               = best_e;
			x.bt.h_src      = H_SRC_VGAP;
			x.bt.gap_model2 = (e2 > e1);
		end else begin
			h               = best_f;
			x.bt.h_src      = H_SRC_HGAP;
			x.bt.gap_model2 = (f2 > f1);
		end
		x.h  = score_t'(h);
		x.e1 = score_t'(e1);
		x.e2 = score_t'(e2);
		x.f1 = score_t'(f1);
		x.f2 = score_t'(f2);
		exp_q.push_back(x);
		due_q.push_back(cyc + CELL_LATENCY);
		// Earliest row keeps a tie
		if (h > max_h) begin
			max_h   = h;
			max_row = row;
		end
		diag    = int'(c.h_left);
		prev_h  = h;
		prev_e1 = e1;
		prev_e2 = e2;
		row++;
		test_cells++;
		total_cells++;
	endtask

	////////////////////////////////////////////////////////////
	// Compare outputs, then follow the input strobes
	////////////////////////////////////////////////////////////

	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			exp_q.delete();
			due_q.delete();
			cyc         = 0;
			done_due    = -1;
			busy        = 1'b0;
			running     = 1'b0;
			error_count = 0;
			test_cells  = 0;
			test_errors = 0;
			total_cells = 0;
			columns     = 0;
		end else begin
			if (cell_out_valid) begin
				if (exp_q.size() == 0) begin
					flag($sformatf("Cell output at cycle %0d with no cell pending", cyc));
				end else begin
					exp_cell = exp_q.pop_front();
					exp_due  = due_q.pop_front();
					if (exp_due != cyc) begin
						flag($sformatf("Cell output at cycle %0d was due at cycle %0d",
							cyc, exp_due));
					end
					check_hex("cell_out.h", 16'(cell_out.h), 16'(exp_cell.h));
					check_hex("cell_out.e1", 16'(cell_out.e1), 16'(exp_cell.e1));
					check_hex("cell_out.e2", 16'(cell_out.e2), 16'(exp_cell.e2));
					check_hex("cell_out.f1", 16'(cell_out.f1), 16'(exp_cell.f1));
					check_hex("cell_out.f2", 16'(cell_out.f2), 16'(exp_cell.f2));
					check_hex("cell_out.bt", 16'(cell_out.bt), 16'(exp_cell.bt));
				end
			end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
				flag($sformatf("Cell output due at cycle %0d never came", due_q[0]));
				exp_cell = exp_q.pop_front();
				exp_due  = due_q.pop_front();
			end

			if (col_done) begin
				if (done_due != cyc) begin
					flag($sformatf("col_done at cycle %0d when none was due", cyc));
				end else begin
					check_hex("col_result.max_h", 16'(col_result.max_h), 16'(max_h));
					check_hex("col_result.max_row", 16'(col_result.max_row), 16'(max_row));
				end
			end else if (done_due == cyc) begin
				flag($sformatf("col_done missing at cycle %0d", cyc));
			end

			// Cells count only while the column runs
			take_cell = cell_valid && running;
			if (take_cell) begin
				model_cell(cell_in);
				if (row == col_len) begin
					running  = 1'b0;
					done_due = cyc + DONE_LATENCY;
					columns++;
				end
			end

			if (col_start_valid && !busy) begin
				busy      = 1'b1;
				running   = 1'b1;
				read_base = col_start.read_base;
				col_len   = int'(col_start.length);
				row       = 0;
				diag      = int'(col_start.h_diag_top);
				prev_h    = int'(col_start.h_top);
				prev_e1   = NEG_INF;
				prev_e2   = NEG_INF;
				max_h     = NEG_INF;
				max_row   = 0;
			end

			// Idle again one cycle after col_done
			if (cyc == done_due) begin
				busy = 1'b0;
			end

			if (test_end) begin
				$display("test %0d finished: %0d cells checked, %0d errors",
					test_num, test_cells, test_errors);
				test_cells  = 0;
				test_errors = 0;
			end

			if (run_end) begin
				if (exp_q.size() != 0) begin
					flag($sformatf("%0d cell outputs still pending at the end", exp_q.size()));
				end
				$display("Checked %0d columns and %0d cells with %0d errors in total",
					columns, total_cells, error_count);
			end
			cyc++;
		end
	end

endmodule

// File: test/tb_align_column_pe.sv
`timescale 1ns/1ps

module tb_align_column_pe import align_pkg::*; ();

	localparam int ROW_WIDTH    = 8;
	localparam int GAP_OPEN1    = 14;
	localparam int GAP_EXT1     = 2;
	localparam int GAP_OPEN2    = 25;
	localparam int GAP_EXT2     = 1;
	localparam int DONE_TIMEOUT = 10;

	logic        sys_clk;
	logic        sys_rst_n;
	logic        col_start_valid;
	col_start_t  col_start;
	logic        cell_valid;
	cell_in_t    cell_in;
	logic        cell_out_valid;
	cell_out_t   cell_out;
	logic        col_done;
	col_result_t col_result;

	logic test_end;
	int   test_num;
	logic run_end;
	int   error_count;
	int   seed;
	int   col;

	align_column_pe #(
		.ROW_WIDTH (ROW_WIDTH),
		.GAP_OPEN1 (GAP_OPEN1),
		.GAP_EXT1  (GAP_EXT1),
		.GAP_OPEN2 (GAP_OPEN2),
		.GAP_EXT2  (GAP_EXT2)
	) DUT (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.col_start_valid (col_start_valid),
		.col_start       (col_start),
		.cell_valid      (cell_valid),
		.cell_in         (cell_in),
		.cell_out_valid  (cell_out_valid),
		.cell_out        (cell_out),
		.col_done        (col_done),
		.col_result      (col_result)
	);

	column_checker #(
		.GAP_OPEN1 (GAP_OPEN1),
		.GAP_EXT1  (GAP_EXT1),
		.GAP_OPEN2 (GAP_OPEN2),
		.GAP_EXT2  (GAP_EXT2)
	) u_checker (
		.sys_clk         (sys_clk),
		.sys_rst_n       (sys_rst_n),
		.col_start_valid (col_start_valid),
		.col_start       (col_start),
		.cell_valid      (cell_valid),
		.cell_in         (cell_in),
		.cell_out_valid  (cell_out_valid),
		.cell_out        (cell_out),
		.col_done        (col_done),
		.col_result      (col_result),
		.test_end        (test_end),
		.test_num        (test_num),
		.run_end         (run_end),
		.error_count     (error_count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	function automatic int rand_int(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	task automatic set_start(input int len, input int span);
		col_start.read_base  = base_t'(rand_int(0, 3));
		col_start.h_top      = score_t'(rand_int(-span, span));
		col_start.h_diag_top = score_t'(rand_int(-span, span));
		col_start.length     = row_t'(len);
	endtask

	task automatic set_cell(input int span);
		cell_in.ref_base = base_t'(rand_int(0, 3));
		cell_in.h_left   = score_t'(rand_int(-span, span));
		cell_in.f1_left  = score_t'(rand_int(-span, span));
		cell_in.f2_left  = score_t'(rand_int(-span, span));
	endtask

	task automatic wait_done();
		int k;
		k = 0;
		while (!col_done && k < DONE_TIMEOUT) begin
			@(negedge sys_clk);
			k++;
		end
		if (col_done) begin
			@(negedge sys_clk);
		end else begin
			$display("Timeout: no col_done within %0d cycles of the last cell", DONE_TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
	endtask

	////////////////////////////////////////////////////////////
	// One column, strobes driven on the falling edge
	////////////////////////////////////////////////////////////

	task automatic drive_column(input int len, input int max_gap, input int span,
			input bit stray);
		int i;
		int gap;
		set_start(len, span);
		col_start_valid = 1'b1;
		@(negedge sys_clk);
		col_start_valid = 1'b0;
		for (i = 0; i < len; i++) begin
			gap = rand_int(0, max_gap);
			repeat (gap) @(negedge sys_clk);
			set_cell(span);
			cell_valid = 1'b1;
			// Start in mid column, to be ignored
			if (stray && i == len / 2) begin
				set_start(rand_int(1, 40), span);
				col_start_valid = 1'b1;
			end
			@(negedge sys_clk);
			cell_valid      = 1'b0;
			col_start_valid = 1'b0;
		end
		// Cell and start while the pipeline flushes
		if (stray) begin
			set_cell(span);
			cell_valid      = 1'b1;
			col_start_valid = 1'b1;
			@(negedge sys_clk);
			cell_valid      = 1'b0;
			col_start_valid = 1'b0;
		end
		wait_done();
	endtask

	task automatic end_test(input int num);
		test_num = num;
		test_end = 1'b1;
		@(negedge sys_clk);
		test_end = 1'b0;
	endtask

	initial begin
		seed            = 93127;
		sys_rst_n       = 1'b0;
		col_start_valid = 1'b0;
		col_start       = '0;
		cell_valid      = 1'b0;
		cell_in         = '0;
		test_end        = 1'b0;
		test_num        = 0;
		run_end         = 1'b0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);

		// Back to back cells
		drive_column(12, 0, 500, 1'b0);
		end_test(1);
		// Random gaps between cells
		drive_column(15, 3, 500, 1'b0);
		end_test(2);
		// Narrow scores, so the maximum often ties
		for (col = 0; col < 4; col++) begin
			drive_column(rand_int(4, 10), 1, 12, 1'b0);
		end
		end_test(3);
		// Stray strobes, first two cells while idle
		set_cell(500);
		cell_valid = 1'b1;
		repeat (2) @(negedge sys_clk);
		cell_valid = 1'b0;
		drive_column(10, 1, 500, 1'b1);
		end_test(4);
		for (col = 0; col < 20; col++) begin
			drive_column((col == 0) ? 1 : rand_int(1, 40), rand_int(0, 2), 500, 1'b0);
		end
		end_test(5);

		run_end = 1'b1;
		@(negedge sys_clk);
		run_end = 1'b0;
		@(negedge sys_clk);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
